// File: verilog.f
verilog/eth_pkg.sv
verilog/axil_ram.sv
verilog/payload_source.sv
verilog/frame_builder.sv
verilog/mii_tx.sv
verilog/board_top.sv
sim/tb_board_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_board_top \
    -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$log_file"; then
    exit 1
fi
exit 0

// File: ram_init.hex
// One 32-bit word per line, word 0 first; payload byte 0 is bits 7:0 of word 0.
deadbeef
0badf00d
13579bdf
2468ace0
c0ffee11
55aa33cc
0f1e2d3c
89abcdef
76543210
fedcba98
a5a55a5a
11223344
99887766
01020408
10204080
7e81c3ff

// File: sim/tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;

    localparam int clk_period = 10;
    localparam int reset_cycles = 10;
    localparam int frame_nibbles = 140;
    localparam int pay_len = 16;
    localparam int min_gap = 24;
    localparam int frames_per_pattern = 3;
    localparam int quiet_cycles = 300;
    // Frame budget is wire time, gap and a fetch margin; setup and quiet time come on top.
    localparam int watchdog_cycles = reset_cycles + 40 +
        4 * frames_per_pattern * (frame_nibbles + min_gap + 200) + 4 * (quiet_cycles + 50);

    // Broadcast UDP datagram from 192.168.1.128 to 192.168.1.255, port 1234 to 1234.
    localparam logic [7:0] exp_header [0:41] = '{
        8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff,
        8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        8'h08, 8'h00,
        8'h45, 8'h00, 8'h00, 8'h2c, 8'h00, 8'h00, 8'h00, 8'h00,
        8'h40, 8'h11, 8'hf5, 8'hf1,
        8'hc0, 8'ha8, 8'h01, 8'h80,
        8'hc0, 8'ha8, 8'h01, 8'hff,
        8'h04, 8'hd2, 8'h04, 8'hd2, 8'h00, 8'h18, 8'h00, 8'h00
    };

    logic       clk_int;
    logic       arst_n;
    logic [3:0] sw;
    logic [3:0] btn;
    logic [7:0] led;
    logic [3:0] phy_txd;
    logic       phy_tx_en;
    logic       phy_reset_n;

    logic [31:0] ram_words [0:15];
    logic [7:0]  frame_bytes [0:79];
    logic [7:0]  led_expect;
    logic        led_valid;
    logic [3:0]  low_nibble;
    logic [1:0]  cur_sel;
    int          value_errors;
    int          other_errors;
    int          nib_cnt;
    int          idle_cnt;
    int          frames_started;
    int          frames_done;

    board_top UUT (
        .clk_int     (clk_int),
        .arst_n      (arst_n),
        .sw          (sw),
        .btn         (btn),
        .led         (led),
        .phy_txd     (phy_txd),
        .phy_tx_en   (phy_tx_en),
        .phy_reset_n (phy_reset_n)
    );

    initial begin
        clk_int = 1'b0;
        forever #(clk_period / 2) clk_int = ~clk_int;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            value_errors++;
            $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Bit-serial CRC-32, data LSB first, reflected polynomial.
    function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] c;
        int b;
        c = crc_in;
        for (b = 0; b < 8; b++) begin
            if (c[0] ^ data[b]) begin
                c = {1'b0, c[31:1]} ^ 32'hedb88320;
            end else begin
                c = {1'b0, c[31:1]};
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] expected_payload(input logic [1:0] sel, input int idx,
                                                    input int seq);
        logic [31:0] w;
        case (sel)
            2'd0: return 8'(idx);
            2'd1: return 8'ha5;
            2'd2: begin
                w = ram_words[idx / 4];
                return w[8 * (idx % 4) +: 8];
            end
            default: return 8'(seq);
        endcase
    endfunction

    task automatic check_frame(input int nibbles, input int seq);
        logic [31:0] crc;
        logic [31:0] fcs;
        logic [31:0] sum;
        int i;
        check_value("phy_tx_en cycles per frame", frame_nibbles, nibbles);
        if (nibbles == frame_nibbles) begin
            for (i = 0; i < 7; i++) begin
                check_value($sformatf("phy_txd preamble byte %0d", i), 32'h55, 32'(frame_bytes[i]));
            end
            check_value("phy_txd SFD byte", 32'hd5, 32'(frame_bytes[7]));
            for (i = 0; i < 42; i++) begin
                check_value($sformatf("phy_txd header byte %0d", i), 32'(exp_header[i]),
                            32'(frame_bytes[8 + i]));
            end
            // The IPv4 header starts 14 bytes into the headers.
            sum = 0;
            for (i = 0; i < 20; i += 2) begin
                sum = sum + 32'({frame_bytes[22 + i], frame_bytes[23 + i]});
            end
            sum = (sum & 32'hffff) + (sum >> 16);
            sum = (sum & 32'hffff) + (sum >> 16);
            check_value("phy_txd IPv4 header sum", 32'hffff, sum);
            for (i = 0; i < pay_len; i++) begin
                check_value($sformatf("phy_txd payload byte %0d", i),
                            32'(expected_payload(cur_sel, i, seq)), 32'(frame_bytes[50 + i]));
            end
            crc = 32'hffffffff;
            for (i = 8; i < 66; i++) begin
                crc = crc_update(crc, frame_bytes[i]);
            end
            fcs = {frame_bytes[69], frame_bytes[68], frame_bytes[67], frame_bytes[66]};
            check_value("phy_txd FCS", ~crc, fcs);
        end
    endtask

    assert property (@(posedge clk_int) phy_tx_en || (phy_txd == 4'd0))
        else report_failure("phy_txd is not zero while phy_tx_en is low");
    assert property (@(posedge clk_int) phy_reset_n || !phy_tx_en)
        else report_failure("phy_tx_en is high while the PHY is held in reset");

    // The LEDs show the inputs of the previous clock edge.
    always @(posedge clk_int) begin
        led_expect <= {sw, 3'b000, btn[0]};
        led_valid <= phy_reset_n;
    end

    always @(negedge clk_int) begin
        if (led_valid) begin
            check_value("led", 32'(led_expect), 32'(led));
        end
    end

    // Nibbles arrive low half first while phy_tx_en is high.
    always @(negedge clk_int) begin
        if (phy_tx_en) begin
            if (nib_cnt == 0) begin
                frames_started++;
                assert (frames_done == 0 || idle_cnt >= min_gap) else
                    report_failure($sformatf("only %0d idle cycles before frame %0d",
                                             idle_cnt, frames_done));
            end
            if (nib_cnt[0] == 1'b0) begin
                low_nibble = phy_txd;
            end else if (nib_cnt / 2 < 80) begin
                frame_bytes[nib_cnt / 2] = {phy_txd, low_nibble};
            end
            nib_cnt++;
            idle_cnt = 0;
        end else begin
            if (nib_cnt != 0) begin
                check_frame(nib_cnt, frames_done);
                frames_done++;
                nib_cnt = 0;
            end
            idle_cnt++;
        end
    end

    initial begin
        int sel;
        int base;
        arst_n = 1'b0;
        sw = 4'h0;
        btn = 4'h0;
        cur_sel = 2'd0;
        value_errors = 0;
        other_errors = 0;
        nib_cnt = 0;
        idle_cnt = 0;
        frames_started = 0;
        frames_done = 0;
        $readmemh("ram_init.hex", ram_words);

        repeat (reset_cycles) @(negedge clk_int);
        check_value("phy_tx_en in reset", 0, 32'(phy_tx_en));
        check_value("led in reset", 0, 32'(led));
        check_value("phy_reset_n in reset", 0, 32'(phy_reset_n));
        arst_n = 1'b1;
        repeat (3) @(negedge clk_int);
        check_value("phy_reset_n after reset", 1, 32'(phy_reset_n));
        check_value("phy_tx_en after reset", 0, 32'(phy_tx_en));

        // Walk the switches with btn[0] low, so no frame starts yet.
        for (sel = 0; sel < 16; sel++) begin
            sw = 4'(sel);
            btn = {3'(sel * 5), 1'b0};
            @(negedge clk_int);
        end

        // Each pattern runs three frames; btn[0] drops inside the third one.
        for (sel = 0; sel < 4; sel++) begin
            base = frames_started;
            cur_sel = 2'(sel);
            sw = {2'(sel + 1), 2'(sel)};
            btn = 4'h0;
            @(negedge clk_int);
            btn = 4'b0001;
            wait (frames_started == base + frames_per_pattern);
            repeat (40) @(negedge clk_int);
            btn = 4'b0000;
            wait (frames_done == base + frames_per_pattern);
            repeat (quiet_cycles) @(negedge clk_int);
            assert (frames_started == base + frames_per_pattern) else
                report_failure("a frame started after btn[0] was released");
        end

        $display("Checks finished: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the frames did not finish within %0d cycles", watchdog_cycles);
        $display("Checks finished: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: verilog/board_top.sv
`timescale 1ns/1ps

module board_top (
    input  logic       clk_int,
    input  logic       arst_n,
    input  logic [3:0] sw,
    input  logic [3:0] btn,
    output logic [7:0] led,
    output logic [3:0] phy_txd,
    output logic       phy_tx_en,
    output logic       phy_reset_n
);

    logic [1:0] rst_sync;
    logic       rst_n_int;

    logic       pay_req;
    logic [3:0] pay_index;
    logic [7:0] frame_seq;
    logic       pay_ack;
    logic [7:0] pay_data;

    eth_pkg::axil_ar_t     ar;
    logic                  ar_ready;
    eth_pkg::axil_r_t      r;
    logic                  r_ready;
    eth_pkg::byte_stream_t tx_stream;
    logic                  tx_ready;

    // Assertion is immediate, release is delayed by two clock edges.
    always_ff @(posedge clk_int or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rst_n_int = rst_sync[1];
    assign phy_reset_n = rst_n_int;

    // Switch and button indicators.
    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            led <= 8'h00;
        end else begin
            led <= {sw, 3'b000, btn[0]};
        end
    end

    frame_builder frame_builder_inst (
        .clk_int       (clk_int),
        .arst_n        (rst_n_int),
        .scream_enable (btn[0]),
        .pay_req       (pay_req),
        .pay_index     (pay_index),
        .frame_seq     (frame_seq),
        .pay_ack       (pay_ack),
        .pay_data      (pay_data),
        .tx_stream     (tx_stream),
        .tx_ready      (tx_ready)
    );

    payload_source payload_source_inst (
        .clk_int     (clk_int),
        .arst_n      (rst_n_int),
        .payload_sel (eth_pkg::payload_sel_t'(sw[1:0])),
        .pay_req     (pay_req),
        .pay_index   (pay_index),
        .frame_seq   (frame_seq),
        .pay_ack     (pay_ack),
        .pay_data    (pay_data),
        .ar          (ar),
        .ar_ready    (ar_ready),
        .r           (r),
        .r_ready     (r_ready)
    );

    axil_ram axil_ram_inst (
        .clk_int  (clk_int),
        .arst_n   (rst_n_int),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r        (r),
        .r_ready  (r_ready)
    );

    mii_tx mii_tx_inst (
        .clk_int   (clk_int),
        .arst_n    (rst_n_int),
        .tx_stream (tx_stream),
        .tx_ready  (tx_ready),
        .phy_txd   (phy_txd),
        .phy_tx_en (phy_tx_en)
    );

endmodule

// File: verilog/mii_tx.sv
`timescale 1ns/1ps

module mii_tx (
    input  logic                  clk_int,
    input  logic                  arst_n,
    input  eth_pkg::byte_stream_t tx_stream,
    output logic                  tx_ready,
    output logic [3:0]            phy_txd,
    output logic                  phy_tx_en
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_fcs
    } state_t;

    state_t      state;
    logic        hi_pending;
    logic        last_q;
    logic [7:0]  byte_q;
    logic [3:0]  byte_cnt;
    logic [31:0] crc;
    logic [27:0] fcs_sr;
    logic [2:0]  fcs_cnt;
    logic [4:0]  gap_cnt;
    logic        accept;

    // One byte of the reflected CRC-32, LSB first.
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        int i;
        c = crc_in ^ {24'd0, d};
        for (i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ eth_pkg::crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    // A byte goes out as two nibbles, so a new one is taken every other cycle.
    assign tx_ready = ((state == st_idle) && (gap_cnt == 5'd0)) ||
                      ((state == st_data) && !hi_pending && !last_q);
    assign accept = tx_stream.valid && tx_ready;

    always_ff @(posedge clk_int) begin
        if (accept) begin
            byte_q <= tx_stream.data;
        end
    end

    always_ff @(posedge clk_int or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            hi_pending <= 1'b0;
            last_q <= 1'b0;
            byte_cnt <= 4'd0;
            crc <= '1;
            fcs_sr <= '0;
            fcs_cnt <= 3'd0;
            gap_cnt <= 5'd0;
            phy_txd <= 4'd0;
            phy_tx_en <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (gap_cnt != 5'd0) begin
                        gap_cnt <= gap_cnt - 5'd1;
                    end
                    if (accept) begin
                        phy_tx_en <= 1'b1;
                        phy_txd <= tx_stream.data[3:0];
                        hi_pending <= 1'b1;
                        last_q <= tx_stream.last;
                        byte_cnt <= 4'd1;
                        crc <= '1;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (hi_pending) begin
                        phy_txd <= byte_q[7:4];
                        hi_pending <= 1'b0;
                    end else if (last_q) begin
                        // The FCS is the inverted CRC, least significant nibble first.
                        phy_txd <= ~crc[3:0];
                        fcs_sr <= ~crc[31:4];
                        fcs_cnt <= 3'd7;
                        state <= st_fcs;
                    end else if (accept) begin
                        phy_txd <= tx_stream.data[3:0];
                        hi_pending <= 1'b1;
                        last_q <= tx_stream.last;
                        if (byte_cnt < 4'(eth_pkg::preamble_len)) begin
                            byte_cnt <= byte_cnt + 4'd1;
                        end else begin
                            crc <= crc_byte(crc, tx_stream.data);
                        end
                    end else begin
                        // Underrun; the frame is cut short.
                        phy_tx_en <= 1'b0;
                        phy_txd <= 4'd0;
                        gap_cnt <= 5'(eth_pkg::ifg_cycles - 1);
                        state <= st_idle;
                    end
                end
                st_fcs: begin
                    if (fcs_cnt != 3'd0) begin
                        phy_txd <= fcs_sr[3:0];
                        fcs_sr <= fcs_sr >> 4;
                        fcs_cnt <= fcs_cnt - 3'd1;
                    end else begin
                        phy_tx_en <= 1'b0;
                        phy_txd <= 4'd0;
                        last_q <= 1'b0;
                        gap_cnt <= 5'(eth_pkg::ifg_cycles - 1);
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: verilog/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
    input  logic                  clk_int,
    input  logic                  arst_n,
    input  logic                  scream_enable,
    output logic                  pay_req,
    output logic [3:0]            pay_index,
    output logic [7:0]            frame_seq,
    input  logic                  pay_ack,
    input  logic [7:0]            pay_data,
    output eth_pkg::byte_stream_t tx_stream,
    input  logic                  tx_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_preamble,
        st_header,
        st_payload
    } state_t;

    state_t     state;
    logic [5:0] cnt;
    logic [7:0] pay_buf [0:eth_pkg::payload_len-1];
    logic       fetch_done;
    logic       take;

    assign fetch_done = (state == st_fetch) && pay_req && pay_ack;
    assign take = tx_stream.valid && tx_ready;

    // The whole payload is buffered first, so the stream never waits on a fetch.
    always_ff @(posedge clk_int) begin
        if (fetch_done) begin
            pay_buf[pay_index] <= pay_data;
        end
    end

    always_ff @(posedge clk_int or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            cnt <= 6'd0;
            pay_req <= 1'b0;
            pay_index <= 4'd0;
            frame_seq <= 8'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (scream_enable) begin
                        pay_index <= 4'd0;
                        pay_req <= 1'b1;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    // Release the request on ack, start the next one once ack is gone.
                    if (fetch_done) begin
                        pay_req <= 1'b0;
                    end else if (!pay_req && !pay_ack) begin
                        if (pay_index == 4'(eth_pkg::payload_len - 1)) begin
                            cnt <= 6'd0;
                            state <= st_preamble;
                        end else begin
                            pay_index <= pay_index + 4'd1;
                            pay_req <= 1'b1;
                        end
                    end
                end
                st_preamble: begin
                    if (take) begin
                        if (cnt == 6'(eth_pkg::preamble_len - 1)) begin
                            cnt <= 6'd0;
                            state <= st_header;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                end
                st_header: begin
                    if (take) begin
                        if (cnt == 6'(eth_pkg::header_len - 1)) begin
                            cnt <= 6'd0;
                            state <= st_payload;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                end
                st_payload: begin
                    if (take) begin
                        if (tx_stream.last) begin
                            frame_seq <= frame_seq + 8'd1;
                            state <= st_idle;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        tx_stream = '0;
        case (state)
            st_preamble: begin
                tx_stream.valid = 1'b1;
                if (cnt == 6'(eth_pkg::preamble_len - 1)) begin
                    tx_stream.data = eth_pkg::sfd_byte;
                end else begin
                    tx_stream.data = eth_pkg::preamble_byte;
                end
            end
            st_header: begin
                tx_stream.valid = 1'b1;
                tx_stream.data = eth_pkg::header_bytes[cnt];
            end
            st_payload: begin
                tx_stream.valid = 1'b1;
                tx_stream.data = pay_buf[cnt[3:0]];
                tx_stream.last = (cnt == 6'(eth_pkg::payload_len - 1));
            end
            default: tx_stream = '0;
        endcase
    end

endmodule

// File: verilog/payload_source.sv
`timescale 1ns/1ps

module payload_source (
    input  logic                  clk_int,
    input  logic                  arst_n,
    input  eth_pkg::payload_sel_t payload_sel,
    input  logic                  pay_req,
    input  logic [3:0]            pay_index,
    input  logic [7:0]            frame_seq,
    output logic                  pay_ack,
    output logic [7:0]            pay_data,
    output eth_pkg::axil_ar_t     ar,
    input  logic                  ar_ready,
    input  eth_pkg::axil_r_t      r,
    output logic                  r_ready
);

    logic              busy;
    logic [7:0]        calc_byte;
    eth_pkg::ram_word_u rd_word;

    assign r_ready = 1'b1;
    assign rd_word.word = r.data;

    always_comb begin
        case (payload_sel)
            eth_pkg::pay_incrementing: calc_byte = {4'd0, pay_index};
            eth_pkg::pay_constant:     calc_byte = 8'ha5;
            default:                   calc_byte = frame_seq;
        endcase
    end

    always_ff @(posedge clk_int or negedge arst_n) begin
        if (!arst_n) begin
            pay_ack <= 1'b0;
            pay_data <= 8'd0;
            ar <= '0;
            busy <= 1'b0;
        end else begin
            if (pay_req && !pay_ack && !busy) begin
                if (payload_sel == eth_pkg::pay_ram) begin
                    // Byte address of the word that holds this payload byte.
                    ar.addr <= {28'd0, pay_index[3:2], 2'b00};
                    ar.valid <= 1'b1;
                    busy <= 1'b1;
                end else begin
                    pay_data <= calc_byte;
                    pay_ack <= 1'b1;
                end
            end

            if (ar.valid && ar_ready) begin
                ar.valid <= 1'b0;
            end

            if (busy && r.valid && r_ready) begin
                pay_data <= rd_word.bytes[pay_index[1:0]];
                pay_ack <= 1'b1;
                busy <= 1'b0;
            end

            // Last phase of the handshake.
            if (!pay_req && pay_ack) begin
                pay_ack <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/axil_ram.sv
`timescale 1ns/1ps

module axil_ram (
    input  logic              clk_int,
    input  logic              arst_n,
    input  eth_pkg::axil_ar_t ar,
    output logic              ar_ready,
    output eth_pkg::axil_r_t  r,
    input  logic              r_ready
);

    logic [31:0]        mem [0:15];
    eth_pkg::ram_word_u rd_word;
    logic               r_valid;

    initial begin
        $readmemh("ram_init.hex", mem);
    end

    // A new address is taken when the output slot is empty or drains this cycle.
    assign ar_ready = !r_valid || r_ready;

    always_ff @(posedge clk_int) begin
        if (ar.valid && ar_ready) begin
            rd_word.word <= mem[ar.addr[5:2]];
        end
    end

    always_ff @(posedge clk_int or negedge arst_n) begin
        if (!arst_n) begin
            r_valid <= 1'b0;
        end else if (ar.valid && ar_ready) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_comb begin
        r.data = rd_word.word;
        r.resp = eth_pkg::axil_resp_okay;
        r.valid = r_valid;
    end

endmodule

// File: verilog/eth_pkg.sv
package eth_pkg;

    // Frame layout. The preamble length counts the SFD byte.
    localparam int preamble_len = 8;
    localparam int header_len = 42;
    localparam int payload_len = 16;
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte = 8'hd5;

    // Idle time between frames, in clock cycles (12 byte times on MII).
    localparam int ifg_cycles = 24;

    // Reflected CRC-32 polynomial, used with LSB-first byte processing.
    localparam logic [31:0] crc_poly = 32'hedb88320;

    localparam logic [1:0] axil_resp_okay = 2'b00;

    // Ethernet, IPv4 and UDP headers for a broadcast datagram.
    // IPv4 total length is 44 and the header checksum F5F1 is precomputed.
    localparam logic [7:0] header_bytes [0:header_len-1] = '{
        8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff,
        8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        8'h08, 8'h00,
        8'h45, 8'h00, 8'h00, 8'h2c, 8'h00, 8'h00, 8'h00, 8'h00,
        8'h40, 8'h11, 8'hf5, 8'hf1,
        8'hc0, 8'ha8, 8'h01, 8'h80,
        8'hc0, 8'ha8, 8'h01, 8'hff,
        8'h04, 8'hd2, 8'h04, 8'hd2, 8'h00, 8'h18, 8'h00, 8'h00
    };

    typedef enum logic [1:0] {
        pay_incrementing = 2'd0,
        pay_constant     = 2'd1,
        pay_ram          = 2'd2,
        pay_frame_count  = 2'd3
    } payload_sel_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        valid;
    } axil_r_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       valid;
    } byte_stream_t;

    // A RAM word seen either whole or as bytes, byte 0 in bits 7:0.
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } ram_word_u;

endpackage
